// File: all.f
hw/audio_pkg.sv
hw/i2s_mic_receiver.sv
hw/offset_estimator.sv
hw/anti_alias_fir.sv
hw/process_audio.sv
hw/audio_front_end.sv
tb/tb_audio_front_end.sv

// File: Bender.yml
package:
  name: audio_front_end

sources:
  - files:
      - hw/audio_pkg.sv
      - hw/i2s_mic_receiver.sv
      - hw/offset_estimator.sv
      - hw/anti_alias_fir.sv
      - hw/process_audio.sv
      - hw/audio_front_end.sv

  - target: test
    files:
      - tb/tb_audio_front_end.sv

// File: tb/tb_audio_front_end.sv
`timescale 1ns/1ns
`default_nettype none

module tb_audio_front_end import audio_pkg::*; ();

    localparam int OFFSET_LOG2  = 4;
    localparam int DECIMATION   = 2;
    localparam int OFFSET_N     = 2 ** OFFSET_LOG2;
    localparam int CONST_FRAMES = 30;
    localparam int STEP_FRAMES  = 4;
    localparam int RAND_FRAMES  = 20;
    localparam int NUM_FRAMES   = OFFSET_N + CONST_FRAMES + STEP_FRAMES + RAND_FRAMES;
    localparam int FRAME_CYCLES = 32 * 8;                              // 32 bits, 8 clocks each.
    localparam int MAX_CYCLES   = (NUM_FRAMES + 8) * FRAME_CYCLES;     // Reset and drain margin.
    localparam sample_t CONST_WORD = 16'sd1234;

    logic       audio_clk;
    logic       rst_in;
    logic       mic_sck;
    logic       mic_ws;
    logic       mic_sd;
    sample_t    raw_sample;
    sample_t    dc_offset;
    logic       offset_ready;
    audio_out_t audio_out;

    logic    rx_valid;
    logic    in_settled;
    int      errors;
    int      n_sent;
    int      rx_count;
    int      pv_count;
    int      frames_since;
    int      cycle_count;
    sample_t exp_offset;
    sample_t settle_value;
    sample_t sent_words [NUM_FRAMES];
    sample_t corrected [NUM_FRAMES];   // Input to the filter after offset removal.
    sample_t exp_out [NUM_FRAMES];

    audio_front_end #(
        .OFFSET_LOG2 (OFFSET_LOG2),
        .DECIMATION  (DECIMATION)
    ) dut (
        .audio_clk    (audio_clk),
        .rst_in       (rst_in),
        .mic_sck      (mic_sck),
        .mic_ws       (mic_ws),
        .mic_sd       (mic_sd),
        .raw_sample   (raw_sample),
        .dc_offset    (dc_offset),
        .offset_ready (offset_ready),
        .audio_out    (audio_out)
    );

    assign rx_valid   = dut.u_mic_rx.sample_valid;
    assign in_settled = (pv_count * DECIMATION >= OFFSET_N + NUM_TAPS - 1)
                     && (pv_count * DECIMATION < OFFSET_N + CONST_FRAMES);

    initial begin
        audio_clk = 1'b0;
        forever #5 audio_clk = ~audio_clk;
    end

    // ########################################################################
    // Reference model
    // ########################################################################

    function automatic longint floor_div(input longint num, input longint den);
        longint q;
        q = num / den;
        if ((num % den != 0) && (num < 0)) begin
            q = q - 1;   // Division truncates toward zero.
        end
        return q;
    endfunction

    function automatic sample_t filter_output(input int n);
        longint acc;
        longint y;
        acc = 0;
        for (int i = 0; i < NUM_TAPS; i++) begin
            if (n - i >= 0) begin
                acc += longint'(fir_coeffs[i]) * longint'(corrected[n - i]);
            end
        end
        y = floor_div(acc + 16384, 32768);
        if (y > 32767) begin
            y = 32767;
        end else if (y < -32768) begin
            y = -32768;
        end
        return sample_t'(y);
    endfunction

    task automatic model_word(input sample_t word);
        longint sum;
        sent_words[n_sent] = word;
        corrected[n_sent]  = (n_sent < OFFSET_N) ? word : sample_t'(word - exp_offset);
        if (n_sent % DECIMATION == 0) begin
            exp_out[n_sent / DECIMATION] = filter_output(n_sent);
        end
        if (n_sent == OFFSET_N - 1) begin
            sum = 0;
            for (int i = 0; i < OFFSET_N; i++) begin
                sum += longint'(sent_words[i]);
            end
            exp_offset   = sample_t'(floor_div(sum, OFFSET_N));
            settle_value = sample_t'(CONST_WORD - exp_offset);
        end
        n_sent++;
    endtask

    // One frame: left word MSB first after the word select fall, then a zero right word.
    task automatic send_frame(input sample_t word);
        model_word(word);
        for (int b = 0; b < 32; b++) begin
            @(posedge audio_clk);
            #1;
            mic_sck = 1'b0;
            mic_sd  = (b < 16) ? word[15 - b] : 1'b0;
            if (b == 0) mic_ws = 1'b0;
            if (b == 16) mic_ws = 1'b1;
            repeat (4) @(posedge audio_clk);
            #1;
            mic_sck = 1'b1;
            repeat (3) @(posedge audio_clk);
        end
    endtask

    function automatic void log_error(input string msg);
        errors++;
        $display("error at %0t ns: %s", $time, msg);
    endfunction

    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            rx_count     <= 0;
            pv_count     <= 0;
            frames_since <= 0;
        end else begin
            if (rx_valid) begin
                rx_count <= rx_count + 1;
            end
            if (audio_out.processed_valid) begin
                pv_count     <= pv_count + 1;
                frames_since <= 0;
            end else if (rx_valid) begin
                frames_since <= frames_since + 1;
            end
        end
    end

    // ########################################################################
    // Checks
    // ########################################################################

    quiet_after_reset: assert property (@(posedge audio_clk) disable iff (rst_in)
        (rx_count == 0) |-> !offset_ready && !audio_out.processed_valid
            && audio_out.processed_sample == 0)
        else log_error("outputs active before the first sample");

    raw_follows_valid: assert property (@(posedge audio_clk) disable iff (rst_in)
        rx_valid |=> raw_sample == sent_words[rx_count - 1])
        else log_error($sformatf("raw_sample %0d differs from the word sent",
            $sampled(raw_sample)));

    raw_changes_on_valid: assert property (@(posedge audio_clk) disable iff (rst_in)
        $changed(raw_sample) |-> $past(rx_valid))
        else log_error("raw_sample changed without a receiver valid");

    offset_at_rise: assert property (@(posedge audio_clk) disable iff (rst_in)
        $rose(offset_ready) |-> dc_offset == exp_offset && rx_count == OFFSET_N)
        else log_error($sformatf("dc_offset %0d at rise, expected %0d",
            $sampled(dc_offset), exp_offset));

    offset_held: assert property (@(posedge audio_clk) disable iff (rst_in)
        offset_ready |=> offset_ready && $stable(dc_offset))
        else log_error("offset estimate did not hold");

    settled_output: assert property (@(posedge audio_clk) disable iff (rst_in)
        audio_out.processed_valid && in_settled |-> audio_out.processed_sample == settle_value)
        else log_error($sformatf("settled output %0d, expected %0d",
            $sampled(audio_out.processed_sample), settle_value));

    single_cycle_pulse: assert property (@(posedge audio_clk) disable iff (rst_in)
        audio_out.processed_valid |=> !audio_out.processed_valid)
        else log_error("processed_valid high in two consecutive cycles");

    pulse_spacing: assert property (@(posedge audio_clk) disable iff (rst_in)
        audio_out.processed_valid && pv_count > 0 |-> frames_since == DECIMATION)
        else log_error($sformatf("%0d input frames between output pulses",
            $sampled(frames_since)));

    output_latency: assert property (@(posedge audio_clk) disable iff (rst_in)
        audio_out.processed_valid |-> $past(rx_valid, NUM_TAPS + 4))
        else log_error("processed_valid latency differs from the receiver valid");

    // A filter output that is not passed on must show up as the odd phase.
    dropped_output_flagged: assert property (@(posedge audio_clk) disable iff (rst_in)
        $past(rx_valid, NUM_TAPS + 4) && !audio_out.processed_valid
            |-> audio_out.decimation_phase)
        else log_error("decimation_phase low after a dropped filter output");

    output_matches_model: assert property (@(posedge audio_clk) disable iff (rst_in)
        audio_out.processed_valid |-> audio_out.processed_sample == exp_out[pv_count]
            && !audio_out.decimation_phase)
        else log_error($sformatf("processed_sample %0d, model %0d",
            $sampled(audio_out.processed_sample), exp_out[$sampled(pv_count)]));

    // ########################################################################
    // Stimulus
    // ########################################################################

    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge audio_clk);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        rst_in  = 1'b1;
        mic_sck = 1'b0;
        mic_ws  = 1'b1;   // Right word idle level.
        mic_sd  = 1'b0;
        errors  = 0;
        n_sent  = 0;
        exp_offset   = '0;
        settle_value = '0;
        void'($urandom(53));
        repeat (8) @(posedge audio_clk);
        #1;
        rst_in = 1'b0;

        for (int i = 0; i < OFFSET_N; i++) begin
            send_frame(sample_t'($urandom()));
        end
        for (int i = 0; i < CONST_FRAMES; i++) begin
            send_frame(CONST_WORD);
        end
        begin : step_and_noise
            sample_t step_word;
            step_word = sample_t'($urandom());
            for (int i = 0; i < STEP_FRAMES; i++) begin
                send_frame(step_word);
            end
            for (int i = 0; i < RAND_FRAMES; i++) begin
                send_frame(sample_t'($urandom()));
            end
        end
        repeat (8) @(posedge audio_clk);

        if (!offset_ready) log_error("offset_ready never rose");
        if (rx_count != n_sent) log_error("receiver delivered the wrong number of words");
        if (pv_count != (n_sent + DECIMATION - 1) / DECIMATION) begin
            log_error("wrong number of decimated outputs");
        end

        $display("summary: %0d errors, %0d words sent, %0d outputs checked",
            errors, n_sent, pv_count);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/audio_front_end.sv
`timescale 1ns/1ns
`default_nettype none

module audio_front_end import audio_pkg::*; #(
    parameter int OFFSET_LOG2 = 4,   // 16 samples for the offset estimate.
    parameter int DECIMATION  = 2    // 48 kHz down to 24 kHz.
) (
    input  wire        audio_clk,
    input  wire        rst_in,
    input  wire        mic_sck,
    input  wire        mic_ws,
    input  wire        mic_sd,
    output sample_t    raw_sample,
    output sample_t    dc_offset,
    output logic       offset_ready,
    output audio_out_t audio_out
);

    sample_t mic_sample;
    logic    mic_valid;

    i2s_mic_receiver u_mic_rx (
        .audio_clk    (audio_clk),
        .rst_in       (rst_in),
        .mic_sck      (mic_sck),
        .mic_ws       (mic_ws),
        .mic_sd       (mic_sd),
        .sample       (mic_sample),
        .sample_valid (mic_valid)
    );

    process_audio #(
        .OFFSET_LOG2 (OFFSET_LOG2),
        .DECIMATION  (DECIMATION)
    ) u_process (
        .audio_clk              (audio_clk),
        .rst_in                 (rst_in),
        .mic_data_valid         (mic_valid),
        .raw_audio_single_cycle (mic_sample),
        .raw_audio_in           (raw_sample),
        .dc_offset              (dc_offset),
        .offset_ready           (offset_ready),
        .audio_out              (audio_out)
    );

endmodule

`default_nettype wire

// File: hw/process_audio.sv
`timescale 1ns/1ns
`default_nettype none

module process_audio import audio_pkg::*; #(
    parameter int OFFSET_LOG2 = 4,
    parameter int DECIMATION  = 2
) (
    input  wire          audio_clk,
    input  wire          rst_in,
    input  wire          mic_data_valid,
    input  wire sample_t raw_audio_single_cycle,
    output sample_t      raw_audio_in,
    output sample_t      dc_offset,
    output logic         offset_ready,
    output audio_out_t   audio_out
);

    localparam int DEC_W = $clog2(DECIMATION);

    logic             raw_valid;   // Lines up with raw_audio_in.
    logic             offset_trigger;
    logic             est_done;
    sample_t          est_offset;
    sample_t          dc_blocked;
    logic             fir_valid;
    sample_t          fir_sample;
    logic [DEC_W-1:0] dec_cnt;

    always_ff @(posedge audio_clk) begin
        if (mic_data_valid) begin
            raw_audio_in <= raw_audio_single_cycle;
        end
    end

    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            raw_valid      <= 1'b0;
            offset_trigger <= 1'b1;   // Falls after the first cycle out of reset.
        end else begin
            raw_valid      <= mic_data_valid;
            offset_trigger <= 1'b0;
        end
    end

    // ########################################################################
    // DC offset removal
    // ########################################################################

    offset_estimator #(.OFFSET_LOG2(OFFSET_LOG2)) u_offset (
        .audio_clk       (audio_clk),
        .rst_in          (rst_in),
        .audio_trigger   (raw_valid),
        .offset_trigger  (offset_trigger),
        .audio_in        (raw_audio_in),
        .offset_produced (est_done),
        .offset          (est_offset)
    );

    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            offset_ready <= 1'b0;
            dc_offset    <= '0;
        end else if (est_done) begin
            offset_ready <= 1'b1;
            dc_offset    <= est_offset;
        end
    end

    assign dc_blocked = offset_ready ? sample_t'(raw_audio_in - dc_offset) : raw_audio_in;

    // ########################################################################
    // Filter and decimation
    // ########################################################################

    anti_alias_fir u_fir (
        .audio_clk  (audio_clk),
        .rst_in     (rst_in),
        .in_valid   (raw_valid),
        .in_sample  (dc_blocked),
        .out_valid  (fir_valid),
        .out_sample (fir_sample)
    );

    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            dec_cnt   <= '0;
            audio_out <= '0;
        end else begin
            audio_out.processed_valid <= 1'b0;
            if (fir_valid) begin
                audio_out.decimation_phase <= (dec_cnt != '0);
                if (dec_cnt == '0) begin
                    audio_out.processed_valid  <= 1'b1;
                    audio_out.processed_sample <= fir_sample;
                end
                dec_cnt <= (dec_cnt == DEC_W'(DECIMATION - 1)) ? '0 : dec_cnt + 1'b1;
            end
        end
    end

    valid_after_filter: assert property (@(posedge audio_clk) disable iff (rst_in)
        audio_out.processed_valid |-> $past(fir_valid))
        else $error("process_audio: processed_valid without filter output");

endmodule

`default_nettype wire

// File: hw/anti_alias_fir.sv
`timescale 1ns/1ns
`default_nettype none

module anti_alias_fir import audio_pkg::*; (
    input  wire          audio_clk,
    input  wire          rst_in,
    input  wire          in_valid,
    input  wire sample_t in_sample,
    output logic         out_valid,
    output sample_t      out_sample
);

    localparam int ACC_W    = 36;
    localparam int SCALED_W = ACC_W - 15;
    localparam int IDX_W    = $clog2(NUM_TAPS);

    fir_state_e                 state;
    sample_t                    delay_line [NUM_TAPS];   // Entry 0 is the newest sample.
    logic [IDX_W-1:0]           tap_idx;
    logic signed [31:0]         product;
    logic signed [ACC_W-1:0]    acc;
    logic signed [ACC_W-1:0]    rounded;
    logic signed [SCALED_W-1:0] scaled;
    sample_t                    saturated;

    // ########################################################################
    // Control and delay line
    // ########################################################################

    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            state     <= FIR_IDLE;
            tap_idx   <= '0;
            out_valid <= 1'b0;
            for (int i = 0; i < NUM_TAPS; i++) begin
                delay_line[i] <= '0;
            end
        end else begin
            out_valid <= 1'b0;
            case (state)
                FIR_IDLE: begin
                    if (in_valid) begin
                        delay_line[0] <= in_sample;
                        for (int i = 1; i < NUM_TAPS; i++) begin
                            delay_line[i] <= delay_line[i-1];
                        end
                        tap_idx <= '0;
                        state   <= FIR_MAC;
                    end
                end
                FIR_MAC: begin
                    if (tap_idx == IDX_W'(NUM_TAPS - 1)) begin
                        tap_idx <= '0;
                        state   <= FIR_ROUND;
                    end else begin
                        tap_idx <= tap_idx + 1'b1;
                    end
                end
                FIR_ROUND: begin
                    out_valid <= 1'b1;
                    state     <= FIR_IDLE;
                end
                default: state <= FIR_IDLE;
            endcase
        end
    end

    // ########################################################################
    // Multiply-accumulate datapath
    // ########################################################################

    assign product = delay_line[tap_idx] * fir_coeffs[tap_idx];

    always_ff @(posedge audio_clk) begin
        case (state)
            FIR_IDLE:  acc <= '0;
            FIR_MAC:   acc <= acc + product;
            FIR_ROUND: out_sample <= saturated;
            default:   acc <= '0;
        endcase
    end

    // Half an LSB before the shift rounds to nearest.
    assign rounded = acc + ACC_W'(16384);
    assign scaled  = rounded[ACC_W-1:15];

    always_comb begin
        if (scaled > 32767) begin
            saturated = 16'sh7fff;
        end else if (scaled < -32768) begin
            saturated = 16'sh8000;
        end else begin
            saturated = scaled[15:0];
        end
    end

    // Upstream samples arrive far apart; a new one must never cut into a pass.
    no_overrun: assert property (@(posedge audio_clk) disable iff (rst_in)
        in_valid |-> state == FIR_IDLE)
        else $error("anti_alias_fir: in_valid while busy");

endmodule

`default_nettype wire

// File: hw/offset_estimator.sv
`timescale 1ns/1ns
`default_nettype none

module offset_estimator import audio_pkg::*; #(
    parameter int OFFSET_LOG2 = 4
) (
    input  wire          audio_clk,
    input  wire          rst_in,
    input  wire          audio_trigger,
    input  wire          offset_trigger,
    input  wire sample_t audio_in,
    output logic         offset_produced,
    output sample_t      offset
);

    localparam int ACC_W = 16 + OFFSET_LOG2;   // Room for 2**OFFSET_LOG2 full-scale samples.

    offset_state_e           state;
    logic [OFFSET_LOG2-1:0]  sample_cnt;
    logic signed [ACC_W-1:0] acc;
    logic signed [ACC_W-1:0] audio_ext;
    logic signed [ACC_W-1:0] mean;

    assign audio_ext = {{OFFSET_LOG2{audio_in[15]}}, audio_in};

    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            state      <= OFS_IDLE;
            sample_cnt <= '0;
            acc        <= '0;
        end else begin
            case (state)
                OFS_IDLE: begin
                    if (offset_trigger) begin
                        state      <= OFS_ACCUM;
                        sample_cnt <= '0;
                        acc        <= '0;
                    end
                end
                OFS_ACCUM: begin
                    if (audio_trigger) begin
                        acc        <= acc + audio_ext;
                        sample_cnt <= sample_cnt + 1'b1;
                        if (&sample_cnt) begin
                            state <= OFS_DONE;
                        end
                    end
                end
                OFS_DONE: state <= OFS_IDLE;   // Single estimate per trigger.
                default:  state <= OFS_IDLE;
            endcase
        end
    end

    // Arithmetic shift gives the floor of the mean, also for negative sums.
    assign mean            = acc >>> OFFSET_LOG2;
    assign offset          = mean[15:0];
    assign offset_produced = (state == OFS_DONE);

    one_cycle_done: assert property (@(posedge audio_clk) disable iff (rst_in)
        $rose(offset_produced) |=> !offset_produced)
        else $error("offset_estimator: offset_produced longer than one cycle");

endmodule

`default_nettype wire

// File: hw/i2s_mic_receiver.sv
`timescale 1ns/1ns
`default_nettype none

module i2s_mic_receiver import audio_pkg::*; (
    input  wire     audio_clk,
    input  wire     rst_in,
    input  wire     mic_sck,
    input  wire     mic_ws,
    input  wire     mic_sd,
    output sample_t sample,
    output logic    sample_valid
);

    // ########################################################################
    // Pin synchronisers and edge detection
    // ########################################################################

    logic [1:0] sck_sync;
    logic [1:0] ws_sync;
    logic [1:0] sd_sync;
    logic       sck_prev;
    logic       ws_prev;
    logic       sck_rise;
    logic       ws_fall;

    // These flush during the reset period, so they carry no reset of their own.
    always_ff @(posedge audio_clk) begin
        sck_sync <= {sck_sync[0], mic_sck};
        ws_sync  <= {ws_sync[0], mic_ws};
        sd_sync  <= {sd_sync[0], mic_sd};
        sck_prev <= sck_sync[1];
        ws_prev  <= ws_sync[1];
    end

    assign sck_rise = sck_sync[1] & ~sck_prev;
    assign ws_fall  = ~ws_sync[1] & ws_prev;   // Start of the left word.

    // ########################################################################
    // Word assembly
    // ########################################################################

    logic [4:0]  bit_cnt;   // Value 16 means the word is complete or not yet started.
    logic [14:0] shift_reg;
    logic        take_bit;

    assign take_bit = sck_rise && (bit_cnt < 5'd16) && !ws_fall;

    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            bit_cnt      <= 5'd16;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= 1'b0;
            if (ws_fall) begin
                bit_cnt <= 5'd0;
            end else if (take_bit) begin
                bit_cnt <= bit_cnt + 5'd1;
                if (bit_cnt == 5'd15) begin
                    sample_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge audio_clk) begin
        if (take_bit) begin
            shift_reg <= {shift_reg[13:0], sd_sync[1]};
            if (bit_cnt == 5'd15) begin
                sample <= {shift_reg, sd_sync[1]};   // MSB arrived first.
            end
        end
    end

    bit_cnt_range: assert property (@(posedge audio_clk) disable iff (rst_in)
        bit_cnt <= 5'd16)
        else $error("i2s_mic_receiver: bit counter above 16");

endmodule

`default_nettype wire

// File: hw/audio_pkg.sv
`default_nettype none

package audio_pkg;

    typedef logic signed [15:0] sample_t;

    localparam int NUM_TAPS = 15;

    // Symmetric low-pass taps in Q1.15. They add up to exactly 32768, so DC passes at unity.
    localparam sample_t fir_coeffs [NUM_TAPS] = '{
        -16'sd120,
        -16'sd250,
        -16'sd180,
        16'sd420,
        16'sd1650,
        16'sd3580,
        16'sd5400,
        16'sd11768,   // Centre tap.
        16'sd5400,
        16'sd3580,
        16'sd1650,
        16'sd420,
        -16'sd180,
        -16'sd250,
        -16'sd120
    };

    typedef enum logic [1:0] {
        OFS_IDLE,
        OFS_ACCUM,
        OFS_DONE
    } offset_state_e;

    typedef enum logic [1:0] {
        FIR_IDLE,
        FIR_MAC,
        FIR_ROUND
    } fir_state_e;

    typedef struct packed {
        logic    processed_valid;
        sample_t processed_sample;
        logic    decimation_phase;   // High when the last filter output was dropped.
    } audio_out_t;

endpackage

`default_nettype wire
